//--- exec_pkg.sv
package exec_pkg;

	typedef enum logic [4:0] {
		alu_add   = 5'd0,
		alu_addc  = 5'd1,
		alu_sub   = 5'd2,
		alu_subc  = 5'd3,
		alu_lsl   = 5'd4,
		alu_lsr   = 5'd5,
		alu_asr   = 5'd6,
		alu_and   = 5'd7,
		alu_or    = 5'd8,
		alu_xor   = 5'd9,
		alu_bic   = 5'd10,
		alu_bst   = 5'd11,
		alu_cmp   = 5'd12,
		alu_movhi = 5'd13,
		alu_copya = 5'd14,
		alu_copyb = 5'd15,
		alu_gcr   = 5'd16,
		alu_scr   = 5'd17,
		alu_swi   = 5'd18,
		alu_rfe   = 5'd19
	} alu_opc_e;

	typedef enum logic [1:0] {
		class_arith  = 2'd0,
		class_branch = 2'd1,
		class_load   = 2'd2,
		class_store  = 2'd3
	} instr_class_e;

	typedef enum logic [2:0] {
		cond_never  = 3'd0,
		cond_ne     = 3'd1,
		cond_eq     = 3'd2,
		cond_cc     = 3'd3,
		cond_cs     = 3'd4,
		cond_gt     = 3'd5,
		cond_lt     = 3'd6,
		cond_always = 3'd7
	} branch_cond_e;

	typedef enum logic [2:0] {
		cr_vector      = 3'd0,
		cr_psr         = 3'd1,
		cr_saved_psr   = 3'd2,
		cr_fault       = 3'd3,
		cr_data_fault  = 3'd4
	} cr_index_e;

	// one word, read as register form or immediate form.
	typedef union packed {
		struct packed {
			instr_class_e cls;
			logic [4:0]   opc;
			logic [3:0]   rd;
			logic [3:0]   ra;
			logic [3:0]   rb;
			logic         op2_rb;
			logic [11:0]  spare;
		} rform;
		struct packed {
			instr_class_e cls;
			logic [4:0]   opc;
			logic [3:0]   rd;
			logic [3:0]   ra;
			logic         op1_pc;
			logic [15:0]  imm;
		} iform;
	} instr_word_u;

endpackage

//--- instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_valid,
	input  exec_pkg::instr_word_u  i_instr,
	input  logic [31:0]            i_pc,
	input  logic [31:0]            i_ra_val,
	input  logic [31:0]            i_rb_val,
	output logic [3:0]             o_ra_sel,
	output logic [3:0]             o_rb_sel,
	output logic                   o_valid,
	output logic [31:0]            o_ra,
	output logic [31:0]            o_rb,
	output logic [31:0]            o_imm32,
	output logic [31:0]            o_pc_plus_4,
	output logic [3:0]             o_rd_sel,
	output logic                   o_update_rd,
	output exec_pkg::alu_opc_e     o_alu_opc,
	output logic                   o_op1_sel_pc,
	output logic                   o_op2_rb,
	output exec_pkg::instr_class_e o_instr_class,
	output logic [1:0]             o_mem_width,
	output exec_pkg::branch_cond_e o_branch_cond,
	output logic                   o_update_flags,
	output logic                   o_update_carry,
	output logic                   o_is_call,
	output logic                   o_is_swi,
	output logic                   o_is_rfe,
	output logic                   o_write_cr,
	output logic [2:0]             o_cr_sel
);

	exec_pkg::instr_class_e cls;
	logic [4:0] opc;
	logic is_arith;
	logic is_branch;
	logic is_mem;
	logic is_call;
	logic reg_form;

	assign cls = i_instr.rform.cls;
	assign opc = i_instr.rform.opc;
	assign is_arith = cls == exec_pkg::class_arith;
	assign is_branch = cls == exec_pkg::class_branch;
	assign is_mem = cls == exec_pkg::class_load || cls == exec_pkg::class_store;
	assign is_call = is_branch && i_instr.rform.rd == 4'hf;

	// loads and stores always take the immediate view.
	assign reg_form = (is_arith || is_branch) && i_instr.rform.op2_rb;

	// read addresses go straight to the register file.
	assign o_ra_sel = i_instr.rform.ra;
	assign o_rb_sel = i_instr.rform.rb;

	always_ff @(posedge clk) begin
		if (rst) begin
			o_valid <= 1'b0;
			o_update_rd <= 1'b0;
			o_update_flags <= 1'b0;
			o_update_carry <= 1'b0;
			o_is_call <= 1'b0;
			o_is_swi <= 1'b0;
			o_is_rfe <= 1'b0;
			o_write_cr <= 1'b0;
			o_instr_class <= exec_pkg::class_arith;
			o_branch_cond <= exec_pkg::cond_never;
		end else begin
			o_valid <= i_valid;
			o_update_rd <= i_valid && ((is_arith && opc != exec_pkg::alu_cmp &&
				opc != exec_pkg::alu_scr) || cls == exec_pkg::class_load || is_call);
			o_update_flags <= i_valid && is_arith && opc == exec_pkg::alu_cmp;
			o_update_carry <= i_valid && is_arith && opc inside {exec_pkg::alu_add,
				exec_pkg::alu_addc, exec_pkg::alu_sub, exec_pkg::alu_subc,
				exec_pkg::alu_cmp};
			o_is_call <= i_valid && is_call;
			o_is_swi <= i_valid && is_branch && opc == exec_pkg::alu_swi;
			o_is_rfe <= i_valid && is_branch && opc == exec_pkg::alu_rfe;
			o_write_cr <= i_valid && is_arith && opc == exec_pkg::alu_scr;
			o_instr_class <= cls;
			o_branch_cond <= is_branch ?
				exec_pkg::branch_cond_e'(i_instr.rform.rd[2:0]) : exec_pkg::cond_never;
		end
	end

	always_ff @(posedge clk) begin
		o_ra <= i_ra_val;
		o_rb <= i_rb_val;
		o_imm32 <= {{16{i_instr.iform.imm[15]}}, i_instr.iform.imm};
		o_pc_plus_4 <= i_pc + 32'd4;
		o_rd_sel <= i_instr.rform.rd;
		// memory ops form their address with an add.
		o_alu_opc <= is_mem ? exec_pkg::alu_add : exec_pkg::alu_opc_e'(opc);
		o_op1_sel_pc <= !reg_form && cls != exec_pkg::class_store &&
			i_instr.iform.op1_pc;
		o_op2_rb <= reg_form;
		o_mem_width <= opc[1:0];
		o_cr_sel <= i_instr.iform.imm[2:0];
	end

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input  logic        clk,
	input  logic        rst,
	input  logic [3:0]  i_ra_sel,
	input  logic [3:0]  i_rb_sel,
	input  logic        i_wr_en,
	input  logic [3:0]  i_wr_sel,
	input  logic [31:0] i_wr_val,
	output logic [31:0] o_ra_val,
	output logic [31:0] o_rb_val
);

	logic [31:0] regs [16];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= 32'h0;
			end
		end else if (i_wr_en) begin
			regs[i_wr_sel] <= i_wr_val;
		end
	end

	// reads see the old value during a write cycle.
	assign o_ra_val = regs[i_ra_sel];
	assign o_rb_val = regs[i_rb_sel];

endmodule

//--- alu.sv
`timescale 1ns/1ns

module alu (
	input  exec_pkg::alu_opc_e i_opc,
	input  logic [31:0]        i_op1,
	input  logic [31:0]        i_op2,
	input  logic               i_carry_in,
	input  logic [31:0]        i_cr_val,
	input  logic [31:0]        i_vector_base,
	input  logic [31:0]        i_fault_address,
	output logic [31:0]        o_result,
	output logic               o_carry,
	output logic               o_overflow,
	output logic               o_negative,
	output logic               o_zero
);

	logic [4:0] shamt;

	assign shamt = i_op2[4:0];
	assign o_zero = i_op1 == i_op2;

	always_comb begin
		o_result = 32'h0;
		o_carry = 1'b0;
		o_overflow = 1'b0;
		o_negative = 1'b0;
		case (i_opc)
			exec_pkg::alu_add:
				{o_carry, o_result} = {1'b0, i_op1} + {1'b0, i_op2};
			exec_pkg::alu_addc:
				{o_carry, o_result} = {1'b0, i_op1} + {1'b0, i_op2} +
					{32'h0, i_carry_in};
			exec_pkg::alu_sub:
				{o_carry, o_result} = {1'b0, i_op1} - {1'b0, i_op2};
			exec_pkg::alu_subc:
				{o_carry, o_result} = {1'b0, i_op1} - {1'b0, i_op2} -
					{32'h0, i_carry_in};
			exec_pkg::alu_lsl:
				{o_carry, o_result} = {1'b0, i_op1} << shamt;
			exec_pkg::alu_lsr: o_result = i_op1 >> shamt;
			exec_pkg::alu_asr: o_result = $signed(i_op1) >>> shamt;
			exec_pkg::alu_and: o_result = i_op1 & i_op2;
			exec_pkg::alu_or: o_result = i_op1 | i_op2;
			exec_pkg::alu_xor: o_result = i_op1 ^ i_op2;
			exec_pkg::alu_bic: o_result = i_op1 & ~(32'h1 << shamt);
			exec_pkg::alu_bst: o_result = i_op1 | (32'h1 << shamt);
			exec_pkg::alu_cmp: begin
				{o_carry, o_result} = {1'b0, i_op1} - {1'b0, i_op2};
				// signed overflow when the operand signs differ and the sign flips.
				o_overflow = (i_op1[31] ^ i_op2[31]) && (o_result[31] != i_op1[31]);
				o_negative = o_result[31];
			end
			exec_pkg::alu_movhi: o_result = {i_op2[15:0], i_op1[15:0]};
			exec_pkg::alu_copya: o_result = i_op1;
			exec_pkg::alu_copyb: o_result = i_op2;
			exec_pkg::alu_gcr: o_result = i_cr_val;
			exec_pkg::alu_swi: o_result = i_vector_base + 32'd8;
			exec_pkg::alu_rfe: o_result = i_fault_address;
			default: o_result = 32'h0;
		endcase
	end

endmodule

//--- ctrl_regs.sv
`timescale 1ns/1ns

module ctrl_regs #(
	parameter logic [31:0] VECTOR_RESET = 32'h0
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        i_write_cr,
	input  logic [2:0]  i_cr_sel,
	input  logic [31:0] i_cr_wr_val,
	input  logic        i_update_flags,
	input  logic        i_update_carry,
	input  logic        i_alu_zero,
	input  logic        i_alu_carry,
	input  logic        i_alu_overflow,
	input  logic        i_alu_negative,
	input  logic        i_swi,
	input  logic        i_rfe,
	input  logic [31:0] i_pc_plus_4,
	input  logic        i_data_abort,
	input  logic [31:0] i_mar,
	input  logic [2:0]  i_dbg_cr_sel,
	input  logic [31:0] i_dbg_cr_wr_val,
	input  logic        i_dbg_cr_wr_en,
	output logic [31:0] o_cr_val,
	output logic [31:0] o_dbg_cr_val,
	output logic [3:0]  o_flags,
	output logic [31:0] o_vector_base,
	output logic [31:0] o_fault_address
);

	// psr is {irq enable, n, o, c, z}.
	logic [25:0] vector_addr;
	logic [4:0]  psr;
	logic [4:0]  saved_psr;
	logic [31:0] fault_address;
	logic [31:0] data_fault_address;
	logic [4:0]  dbg_wr;
	logic [4:0]  scr_wr;
	logic [31:0] cr_view [8];

	assign dbg_wr = i_dbg_cr_wr_en ? 5'b1 << i_dbg_cr_sel : 5'b0;
	assign scr_wr = i_write_cr ? 5'b1 << i_cr_sel : 5'b0;

	always_ff @(posedge clk) begin
		if (rst) begin
			vector_addr <= VECTOR_RESET[31:6];
			psr <= 5'b0;
			saved_psr <= 5'b0;
			fault_address <= 32'h0;
			data_fault_address <= 32'h0;
		end else begin
			if (dbg_wr[0]) vector_addr <= i_dbg_cr_wr_val[31:6];
			else if (scr_wr[0]) vector_addr <= i_cr_wr_val[31:6];

			if (dbg_wr[1]) begin
				psr <= i_dbg_cr_wr_val[4:0];
			end else if (i_rfe) begin
				psr <= saved_psr;
			end else if (i_swi) begin
				psr[4] <= 1'b0;
			end else if (i_update_flags || i_update_carry) begin
				if (i_update_flags) begin
					psr[3] <= i_alu_negative;
					psr[2] <= i_alu_overflow;
					psr[0] <= i_alu_zero;
				end
				if (i_update_carry) psr[1] <= i_alu_carry;
			end else if (scr_wr[1]) begin
				psr <= i_cr_wr_val[4:0];
			end

			if (dbg_wr[2]) saved_psr <= i_dbg_cr_wr_val[4:0];
			else if (i_swi) saved_psr <= psr;
			else if (scr_wr[2]) saved_psr <= i_cr_wr_val[4:0];

			if (dbg_wr[3]) fault_address <= i_dbg_cr_wr_val;
			else if (i_swi) fault_address <= i_pc_plus_4;
			else if (scr_wr[3]) fault_address <= i_cr_wr_val;

			if (dbg_wr[4]) data_fault_address <= i_dbg_cr_wr_val;
			else if (i_data_abort) data_fault_address <= i_mar;
			else if (scr_wr[4]) data_fault_address <= i_cr_wr_val;
		end
	end

	// unused indices read as zero.
	always_comb begin
		cr_view = '{default: 32'h0};
		cr_view[exec_pkg::cr_vector] = {vector_addr, 6'h0};
		cr_view[exec_pkg::cr_psr] = {27'h0, psr};
		cr_view[exec_pkg::cr_saved_psr] = {27'h0, saved_psr};
		cr_view[exec_pkg::cr_fault] = fault_address;
		cr_view[exec_pkg::cr_data_fault] = data_fault_address;
	end

	assign o_cr_val = cr_view[i_cr_sel];
	assign o_dbg_cr_val = cr_view[i_dbg_cr_sel];
	assign o_flags = psr[3:0];
	assign o_vector_base = {vector_addr, 6'h0};
	assign o_fault_address = fault_address;

endmodule

//--- exec_stage.sv
`timescale 1ns/1ns

module exec_stage #(
	parameter logic [31:0] VECTOR_RESET = 32'h0
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_valid,
	input  logic [31:0]            i_ra,
	input  logic [31:0]            i_rb,
	input  logic [31:0]            i_imm32,
	input  logic [31:0]            i_pc_plus_4,
	input  logic [3:0]             i_rd_sel,
	input  logic                   i_update_rd,
	input  exec_pkg::alu_opc_e     i_alu_opc,
	input  logic                   i_op1_sel_pc,
	input  logic                   i_op2_rb,
	input  exec_pkg::instr_class_e i_instr_class,
	input  logic [1:0]             i_mem_width,
	input  exec_pkg::branch_cond_e i_branch_cond,
	input  logic                   i_update_flags,
	input  logic                   i_update_carry,
	input  logic                   i_is_call,
	input  logic                   i_is_swi,
	input  logic                   i_is_rfe,
	input  logic                   i_write_cr,
	input  logic [2:0]             i_cr_sel,
	input  logic                   i_data_abort,
	input  logic [2:0]             i_dbg_cr_sel,
	input  logic [31:0]            i_dbg_cr_wr_val,
	input  logic                   i_dbg_cr_wr_en,
	output logic [31:0]            o_dbg_cr_val,
	output logic                   o_valid,
	output logic                   o_wr_result,
	output logic [3:0]             o_rd_sel,
	output logic [31:0]            o_wr_val,
	output logic                   o_branch_taken,
	output logic [31:0]            o_branch_target,
	output logic                   o_mem_load,
	output logic                   o_mem_store,
	output logic [1:0]             o_mem_width,
	output logic [31:0]            o_mar,
	output logic [31:0]            o_mdr
);

	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] alu_result;
	logic        alu_carry;
	logic        alu_overflow;
	logic        alu_negative;
	logic        alu_zero;
	logic [31:0] cr_val;
	logic [31:0] vector_base;
	logic [31:0] fault_address;
	logic [3:0]  flags;
	logic        cond_met;
	logic        is_load;
	logic        is_store;

	assign op1 = i_op1_sel_pc ? i_pc_plus_4 : i_ra;
	assign op2 = i_op2_rb ? i_rb : i_imm32;
	assign is_load = i_valid && i_instr_class == exec_pkg::class_load;
	assign is_store = i_valid && i_instr_class == exec_pkg::class_store;

	alu u_alu (
		.i_opc           (i_alu_opc),
		.i_op1           (op1),
		.i_op2           (op2),
		.i_carry_in      (flags[1]),
		.i_cr_val        (cr_val),
		.i_vector_base   (vector_base),
		.i_fault_address (fault_address),
		.o_result        (alu_result),
		.o_carry         (alu_carry),
		.o_overflow      (alu_overflow),
		.o_negative      (alu_negative),
		.o_zero          (alu_zero)
	);

	// scr writes the value of ra.
	ctrl_regs #(
		.VECTOR_RESET (VECTOR_RESET)
	) u_ctrl_regs (
		.clk             (clk),
		.rst             (rst),
		.i_write_cr      (i_write_cr),
		.i_cr_sel        (i_cr_sel),
		.i_cr_wr_val     (i_ra),
		.i_update_flags  (i_update_flags),
		.i_update_carry  (i_update_carry),
		.i_alu_zero      (alu_zero),
		.i_alu_carry     (alu_carry),
		.i_alu_overflow  (alu_overflow),
		.i_alu_negative  (alu_negative),
		.i_swi           (i_is_swi),
		.i_rfe           (i_is_rfe),
		.i_pc_plus_4     (i_pc_plus_4),
		.i_data_abort    (i_data_abort),
		.i_mar           (o_mar),
		.i_dbg_cr_sel    (i_dbg_cr_sel),
		.i_dbg_cr_wr_val (i_dbg_cr_wr_val),
		.i_dbg_cr_wr_en  (i_dbg_cr_wr_en),
		.o_cr_val        (cr_val),
		.o_dbg_cr_val    (o_dbg_cr_val),
		.o_flags         (flags),
		.o_vector_base   (vector_base),
		.o_fault_address (fault_address)
	);

	// flags are {n, o, c, z}.
	always_comb begin
		case (i_branch_cond)
			exec_pkg::cond_ne: cond_met = !flags[0];
			exec_pkg::cond_eq: cond_met = flags[0];
			exec_pkg::cond_cc: cond_met = !flags[1];
			exec_pkg::cond_cs: cond_met = flags[1];
			exec_pkg::cond_gt: cond_met = !flags[0] && (flags[3] == flags[2]);
			exec_pkg::cond_lt: cond_met = flags[3] != flags[2];
			exec_pkg::cond_always: cond_met = 1'b1;
			default: cond_met = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			o_valid <= 1'b0;
			o_wr_result <= 1'b0;
			o_branch_taken <= 1'b0;
			o_mem_load <= 1'b0;
			o_mem_store <= 1'b0;
		end else begin
			o_valid <= i_valid;
			o_wr_result <= i_update_rd;
			o_branch_taken <= i_valid && i_instr_class == exec_pkg::class_branch &&
				(cond_met || i_is_swi || i_is_rfe);
			o_mem_load <= is_load;
			o_mem_store <= is_store;
		end
	end

	always_ff @(posedge clk) begin
		o_rd_sel <= i_rd_sel;
		o_wr_val <= i_is_call ? i_pc_plus_4 : alu_result;
		o_branch_target <= alu_result;
		if (is_load || is_store) begin
			o_mem_width <= i_mem_width;
			o_mar <= alu_result;
		end
		if (is_store) o_mdr <= i_rb;
	end

endmodule

//--- exec_top.sv
`timescale 1ns/1ns

module exec_top #(
	parameter logic [31:0] VECTOR_RESET = 32'h0
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        i_valid,
	input  logic [31:0] i_instr,
	input  logic [31:0] i_pc,
	input  logic        i_data_abort,
	input  logic [2:0]  i_dbg_cr_sel,
	input  logic [31:0] i_dbg_cr_wr_val,
	input  logic        i_dbg_cr_wr_en,
	output logic [31:0] o_dbg_cr_val,
	output logic        o_valid,
	output logic        o_wr_result,
	output logic [3:0]  o_rd_sel,
	output logic [31:0] o_wr_val,
	output logic        o_branch_taken,
	output logic [31:0] o_branch_target,
	output logic        o_mem_load,
	output logic        o_mem_store,
	output logic [1:0]  o_mem_width,
	output logic [31:0] o_mar,
	output logic [31:0] o_mdr
);

	logic [3:0]             ra_sel;
	logic [3:0]             rb_sel;
	logic [31:0]            ra_val;
	logic [31:0]            rb_val;
	logic                   d_valid;
	logic [31:0]            d_ra;
	logic [31:0]            d_rb;
	logic [31:0]            d_imm32;
	logic [31:0]            d_pc_plus_4;
	logic [3:0]             d_rd_sel;
	logic                   d_update_rd;
	exec_pkg::alu_opc_e     d_alu_opc;
	logic                   d_op1_sel_pc;
	logic                   d_op2_rb;
	exec_pkg::instr_class_e d_instr_class;
	logic [1:0]             d_mem_width;
	exec_pkg::branch_cond_e d_branch_cond;
	logic                   d_update_flags;
	logic                   d_update_carry;
	logic                   d_is_call;
	logic                   d_is_swi;
	logic                   d_is_rfe;
	logic                   d_write_cr;
	logic [2:0]             d_cr_sel;

	instr_decode u_instr_decode (
		.clk            (clk),
		.rst            (rst),
		.i_valid        (i_valid),
		.i_instr        (i_instr),
		.i_pc           (i_pc),
		.i_ra_val       (ra_val),
		.i_rb_val       (rb_val),
		.o_ra_sel       (ra_sel),
		.o_rb_sel       (rb_sel),
		.o_valid        (d_valid),
		.o_ra           (d_ra),
		.o_rb           (d_rb),
		.o_imm32        (d_imm32),
		.o_pc_plus_4    (d_pc_plus_4),
		.o_rd_sel       (d_rd_sel),
		.o_update_rd    (d_update_rd),
		.o_alu_opc      (d_alu_opc),
		.o_op1_sel_pc   (d_op1_sel_pc),
		.o_op2_rb       (d_op2_rb),
		.o_instr_class  (d_instr_class),
		.o_mem_width    (d_mem_width),
		.o_branch_cond  (d_branch_cond),
		.o_update_flags (d_update_flags),
		.o_update_carry (d_update_carry),
		.o_is_call      (d_is_call),
		.o_is_swi       (d_is_swi),
		.o_is_rfe       (d_is_rfe),
		.o_write_cr     (d_write_cr),
		.o_cr_sel       (d_cr_sel)
	);

	// writeback comes from the exec output registers.
	reg_file u_reg_file (
		.clk      (clk),
		.rst      (rst),
		.i_ra_sel (ra_sel),
		.i_rb_sel (rb_sel),
		.i_wr_en  (o_wr_result),
		.i_wr_sel (o_rd_sel),
		.i_wr_val (o_wr_val),
		.o_ra_val (ra_val),
		.o_rb_val (rb_val)
	);

	exec_stage #(
		.VECTOR_RESET (VECTOR_RESET)
	) u_exec_stage (
		.clk             (clk),
		.rst             (rst),
		.i_valid         (d_valid),
		.i_ra            (d_ra),
		.i_rb            (d_rb),
		.i_imm32         (d_imm32),
		.i_pc_plus_4     (d_pc_plus_4),
		.i_rd_sel        (d_rd_sel),
		.i_update_rd     (d_update_rd),
		.i_alu_opc       (d_alu_opc),
		.i_op1_sel_pc    (d_op1_sel_pc),
		.i_op2_rb        (d_op2_rb),
		.i_instr_class   (d_instr_class),
		.i_mem_width     (d_mem_width),
		.i_branch_cond   (d_branch_cond),
		.i_update_flags  (d_update_flags),
		.i_update_carry  (d_update_carry),
		.i_is_call       (d_is_call),
		.i_is_swi        (d_is_swi),
		.i_is_rfe        (d_is_rfe),
		.i_write_cr      (d_write_cr),
		.i_cr_sel        (d_cr_sel),
		.i_data_abort    (i_data_abort),
		.i_dbg_cr_sel    (i_dbg_cr_sel),
		.i_dbg_cr_wr_val (i_dbg_cr_wr_val),
		.i_dbg_cr_wr_en  (i_dbg_cr_wr_en),
		.o_dbg_cr_val    (o_dbg_cr_val),
		.o_valid         (o_valid),
		.o_wr_result     (o_wr_result),
		.o_rd_sel        (o_rd_sel),
		.o_wr_val        (o_wr_val),
		.o_branch_taken  (o_branch_taken),
		.o_branch_target (o_branch_target),
		.o_mem_load      (o_mem_load),
		.o_mem_store     (o_mem_store),
		.o_mem_width     (o_mem_width),
		.o_mar           (o_mar),
		.o_mdr           (o_mdr)
	);

endmodule

//--- tb_exec_top.sv
`timescale 1ns/1ns

module tb_exec_top;

	typedef struct packed {
		logic        valid;
		logic        wr;
		logic [3:0]  rd;
		logic [31:0] wr_val;
		logic        taken;
		logic [31:0] target;
		logic        ld;
		logic        st;
		logic [1:0]  width;
		logic [31:0] mar;
		logic [31:0] mdr;
	} exp_t;

	localparam int num_instr = 140;
	localparam int timeout_ns = num_instr * 400 + 20000;

	logic clk, rst, i_valid, i_data_abort, i_dbg_cr_wr_en;
	logic [31:0] i_instr, i_pc, i_dbg_cr_wr_val;
	logic [2:0] i_dbg_cr_sel;
	logic [31:0] o_dbg_cr_val, o_wr_val, o_branch_target, o_mar, o_mdr;
	logic o_valid, o_wr_result, o_branch_taken, o_mem_load, o_mem_store;
	logic [3:0] o_rd_sel;
	logic [1:0] o_mem_width;

	// reference state with the psr as {irq enable, n, o, c, z}.
	logic [31:0] m_regs [16];
	logic [4:0]  m_psr, m_saved;
	logic [25:0] m_vec;
	logic [31:0] m_fault, m_dfault, m_mar, pc;
	exp_t exp_q [$];
	exp_t cur;
	int errors, checks, seed;

	exec_top #(.VECTOR_RESET(32'h0)) u_exec_top (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		#(timeout_ns);
		$display("timeout: the run did not finish in time, errors %0d", errors);
		$display("Verification failed");
		$finish;
	end

	function automatic logic [31:0] cr_read(input logic [2:0] sel);
		case (sel)
			3'd0: return {m_vec, 6'h0};
			3'd1: return {27'h0, m_psr};
			3'd2: return {27'h0, m_saved};
			3'd3: return m_fault;
			3'd4: return m_dfault;
			default: return 32'h0;
		endcase
	endfunction

	task automatic cr_write(input logic [2:0] sel, input logic [31:0] val);
		case (sel)
			3'd0: m_vec = val[31:6];
			3'd1: m_psr = val[4:0];
			3'd2: m_saved = val[4:0];
			3'd3: m_fault = val;
			3'd4: m_dfault = val;
			default: ;
		endcase
	endtask

	function automatic logic [31:0] make_i(input exec_pkg::instr_class_e c,
		input exec_pkg::alu_opc_e o, input logic [3:0] rd, input logic [3:0] ra,
		input logic pcsel, input logic [15:0] imm);
		exec_pkg::instr_word_u u;
		u.iform.cls = c;
		u.iform.opc = o;
		u.iform.rd = rd;
		u.iform.ra = ra;
		u.iform.op1_pc = pcsel;
		u.iform.imm = imm;
		return u;
	endfunction

	function automatic logic [31:0] make_r(input exec_pkg::instr_class_e c,
		input exec_pkg::alu_opc_e o, input logic [3:0] rd, input logic [3:0] ra,
		input logic [3:0] rb);
		exec_pkg::instr_word_u u;
		u.rform.cls = c;
		u.rform.opc = o;
		u.rform.rd = rd;
		u.rform.ra = ra;
		u.rform.rb = rb;
		u.rform.op2_rb = 1'b1;
		u.rform.spare = 12'h0;
		return u;
	endfunction

	// executes one word on the reference state and forms its expected outputs.
	task automatic model_issue(input logic [31:0] w, output exp_t e);
		logic [1:0] cls;
		logic [4:0] opc;
		logic [3:0] rd;
		logic [31:0] op1, op2, imm, res;
		logic [32:0] wide;
		logic reg_form, op1_pc, cmet, call, swi, rfe, upd_rd;
		logic [4:0] sh;
		cls = w[31:30];
		opc = (cls >= 2'd2) ? 5'd0 : w[29:25];
		rd = w[24:21];
		imm = {{16{w[15]}}, w[15:0]};
		reg_form = (cls <= 2'd1) && w[12];
		op1_pc = !reg_form && cls != 2'd3 && w[16];
		op1 = op1_pc ? pc + 32'd4 : m_regs[w[20:17]];
		op2 = reg_form ? m_regs[w[16:13]] : imm;
		sh = op2[4:0];
		wide = {1'b0, op1} + {1'b0, op2};
		case (opc)
			exec_pkg::alu_addc: wide = {1'b0, op1} + {1'b0, op2} + m_psr[1];
			exec_pkg::alu_sub, exec_pkg::alu_cmp: wide = {1'b0, op1} - {1'b0, op2};
			exec_pkg::alu_subc: wide = {1'b0, op1} - {1'b0, op2} - m_psr[1];
			default: ;
		endcase
		case (opc)
			exec_pkg::alu_lsl: res = op1 << sh;
			exec_pkg::alu_lsr: res = op1 >> sh;
			exec_pkg::alu_asr: res = $signed(op1) >>> sh;
			exec_pkg::alu_and: res = op1 & op2;
			exec_pkg::alu_or: res = op1 | op2;
			exec_pkg::alu_xor: res = op1 ^ op2;
			exec_pkg::alu_bic: res = op1 & ~(32'h1 << sh);
			exec_pkg::alu_bst: res = op1 | (32'h1 << sh);
			exec_pkg::alu_movhi: res = {op2[15:0], op1[15:0]};
			exec_pkg::alu_copya: res = op1;
			exec_pkg::alu_copyb: res = op2;
			exec_pkg::alu_gcr: res = cr_read(w[2:0]);
			exec_pkg::alu_swi: res = {m_vec, 6'h0} + 32'd8;
			exec_pkg::alu_rfe: res = m_fault;
			default: res = (opc <= 5'd3 || opc == 5'd12) ? wide[31:0] : 32'h0;
		endcase
		case (cls == 2'd1 ? w[23:21] : 3'd0)
			3'd1: cmet = !m_psr[0];
			3'd2: cmet = m_psr[0];
			3'd3: cmet = !m_psr[1];
			3'd4: cmet = m_psr[1];
			3'd5: cmet = !m_psr[0] && m_psr[3] == m_psr[2];
			3'd6: cmet = m_psr[3] != m_psr[2];
			3'd7: cmet = 1'b1;
			default: cmet = 1'b0;
		endcase
		call = cls == 2'd1 && rd == 4'hf;
		swi = cls == 2'd1 && opc == exec_pkg::alu_swi;
		rfe = cls == 2'd1 && opc == exec_pkg::alu_rfe;
		upd_rd = (cls == 2'd0 && opc != exec_pkg::alu_cmp && opc != exec_pkg::alu_scr) ||
			cls == 2'd2 || call;
		e.valid = 1'b1;
		e.wr = upd_rd;
		e.rd = rd;
		e.wr_val = call ? pc + 32'd4 : res;
		e.taken = cls == 2'd1 && (cmet || swi || rfe);
		e.target = res;
		e.ld = cls == 2'd2;
		e.st = cls == 2'd3;
		e.width = w[26:25];
		e.mar = res;
		e.mdr = m_regs[w[16:13]];
		if (cls == 2'd0 && opc == exec_pkg::alu_cmp) begin
			m_psr[3] = res[31];
			m_psr[2] = (op1[31] ^ op2[31]) && (res[31] != op1[31]);
			m_psr[0] = op1 == op2;
		end
		if (cls == 2'd0 && (opc <= 5'd3 || opc == exec_pkg::alu_cmp))
			m_psr[1] = wide[32];
		if (cls == 2'd0 && opc == exec_pkg::alu_scr)
			cr_write(w[2:0], m_regs[w[20:17]]);
		if (swi) begin
			m_saved = m_psr;
			m_psr[4] = 1'b0;
			m_fault = pc + 32'd4;
		end
		if (rfe)
			m_psr = m_saved;
		if (e.ld || e.st)
			m_mar = res;
		if (upd_rd)
			m_regs[rd] = e.wr_val;
	endtask

	task automatic step(input logic v, input logic [31:0] w, input logic abort);
		exp_t e;
		@(posedge clk);
		#5;
		i_valid = v;
		i_instr = w;
		i_pc = pc;
		i_data_abort = abort;
		i_dbg_cr_wr_en = 1'b0;
		e = '0;
		if (v) begin
			model_issue(w, e);
			pc = pc + 32'd4;
		end
		if (abort)
			m_dfault = m_mar;
		exp_q.push_back(e);
	endtask

	// every instruction is followed by two bubbles.
	task automatic issue(input logic [31:0] w);
		step(1'b1, w, 1'b0);
		step(1'b0, 32'h0, 1'b0);
		step(1'b0, 32'h0, 1'b0);
	endtask

	task automatic drain();
		repeat (3) step(1'b0, 32'h0, 1'b0);
	endtask

	task automatic set_reg(input logic [3:0] r, input logic [15:0] v);
		issue(make_i(exec_pkg::class_arith, exec_pkg::alu_copyb, r, 4'h0, 1'b0, v));
	endtask

	task automatic dbg_write(input logic [2:0] sel, input logic [31:0] val);
		step(1'b0, 32'h0, 1'b0);
		i_dbg_cr_wr_en = 1'b1;
		i_dbg_cr_sel = sel;
		i_dbg_cr_wr_val = val;
		cr_write(sel, val);
	endtask

	task automatic check_cr(input logic [2:0] sel);
		step(1'b0, 32'h0, 1'b0);
		i_dbg_cr_sel = sel;
		@(negedge clk);
		checks++;
		assert (o_dbg_cr_val == cr_read(sel)) else begin
			errors++;
			$display("mismatch at %0t: CR%0d reads %h, expected %h", $time, sel,
				o_dbg_cr_val, cr_read(sel));
		end
	endtask

	// results of the slot driven two edges ago.
	always @(negedge clk) begin
		if (!rst && exp_q.size() >= 3) begin
			cur = exp_q.pop_front();
			checks++;
			assert (o_valid == cur.valid && o_wr_result == cur.wr &&
				(!cur.wr || (o_rd_sel == cur.rd && o_wr_val == cur.wr_val))) else begin
				errors++;
				$display("mismatch at %0t: result r%0d=%h wr %b, expected r%0d=%h wr %b",
					$time, o_rd_sel, o_wr_val, o_wr_result, cur.rd, cur.wr_val, cur.wr);
			end
			assert (o_branch_taken == cur.taken &&
				(!cur.taken || o_branch_target == cur.target)) else begin
				errors++;
				$display("mismatch at %0t: branch %b to %h, expected %b to %h", $time,
					o_branch_taken, o_branch_target, cur.taken, cur.target);
			end
			assert (o_mem_load == cur.ld && o_mem_store == cur.st &&
				(!(cur.ld || cur.st) || (o_mar == cur.mar && o_mem_width == cur.width)) &&
				(!cur.st || o_mdr == cur.mdr)) else begin
				errors++;
				$display("mismatch at %0t: memory mar %h mdr %h width %0d", $time,
					o_mar, o_mdr, o_mem_width);
			end
		end
	end

	initial begin
		logic [4:0] opc;
		logic [15:0] imm;
		rst = 1'b1;
		i_valid = 1'b0;
		i_instr = 32'h0;
		i_pc = 32'h0;
		i_data_abort = 1'b0;
		i_dbg_cr_sel = 3'd0;
		i_dbg_cr_wr_val = 32'h0;
		i_dbg_cr_wr_en = 1'b0;
		errors = 0;
		checks = 0;
		seed = 32'h3f16ffbb;
		pc = 32'h1000;
		for (int i = 0; i < 16; i++)
			m_regs[i] = 32'h0;
		m_psr = 5'h0;
		m_saved = 5'h0;
		m_vec = 26'h0;
		m_fault = 32'h0;
		m_dfault = 32'h0;
		m_mar = 32'h0;
		repeat (2) @(posedge clk);
		#5 rst = 1'b0;

		// random arithmetic in both forms.
		for (int i = 0; i < 40; i++) begin
			opc = 5'({$random(seed)} % 16);
			imm = $random(seed);
			imm[12] = 1'b0;
			if ($random(seed) & 1)
				issue(make_r(exec_pkg::class_arith, exec_pkg::alu_opc_e'(opc),
					4'($random(seed)), 4'($random(seed)), 4'($random(seed))));
			else
				issue(make_i(exec_pkg::class_arith, exec_pkg::alu_opc_e'(opc),
					4'($random(seed)), 4'($random(seed)), 1'($random(seed)), imm));
		end

		// each condition after cmp of equal, lower, higher, negative and overflow pairs.
		for (int p = 0; p < 5; p++) begin
			set_reg(4'd1, p == 2 ? 16'd9 : (p == 3 ? 16'he003 : (p == 4 ? 16'd3 : 16'd5)));
			if (p == 4)
				issue(make_i(exec_pkg::class_arith, exec_pkg::alu_movhi, 4'd1, 4'd1,
					1'b0, 16'h8000));
			set_reg(4'd2, p == 1 ? 16'd9 : 16'd5);
			issue(make_r(exec_pkg::class_arith, exec_pkg::alu_cmp, 4'd0, 4'd1, 4'd2));
			for (int c = 0; c < 8; c++)
				issue(make_i(exec_pkg::class_branch, exec_pkg::alu_add, 4'(c), 4'd0,
					1'b1, 16'h0040));
		end
		issue(make_i(exec_pkg::class_branch, exec_pkg::alu_add, 4'hf, 4'd0, 1'b1,
			16'h0100));

		// loads and stores of every width.
		set_reg(4'd1, 16'h0800);
		for (int wd = 0; wd < 4; wd++) begin
			issue(make_i(exec_pkg::class_load, exec_pkg::alu_opc_e'(wd), 4'd5, 4'd1,
				1'b0, 16'h0024));
			issue(make_i(exec_pkg::class_store, exec_pkg::alu_opc_e'(wd), 4'd0, 4'd1,
				1'b0, 16'h2010 + 16'(wd * 4)));
		end

		// debug access, then gcr and scr.
		drain();
		for (int i = 0; i < 5; i++)
			dbg_write(3'(i), $random(seed));
		for (int i = 0; i < 8; i++)
			check_cr(3'(i));
		for (int i = 0; i < 5; i++)
			issue(make_i(exec_pkg::class_arith, exec_pkg::alu_gcr, 4'd3, 4'd0, 1'b0,
				16'(i)));
		set_reg(4'd4, 16'h0ac3);
		for (int i = 0; i < 5; i++)
			issue(make_i(exec_pkg::class_arith, exec_pkg::alu_scr, 4'd0, 4'd4, 1'b0,
				16'(i)));
		drain();
		for (int i = 0; i < 5; i++)
			check_cr(3'(i));

		// swi and rfe.
		dbg_write(3'd1, 32'h16);
		dbg_write(3'd0, 32'h1000);
		issue(make_i(exec_pkg::class_branch, exec_pkg::alu_swi, 4'd0, 4'd0, 1'b0, 16'h0));
		drain();
		for (int i = 1; i < 4; i++)
			check_cr(3'(i));
		issue(make_i(exec_pkg::class_branch, exec_pkg::alu_rfe, 4'd0, 4'd0, 1'b0, 16'h0));
		drain();
		check_cr(3'd1);

		// data abort one cycle after a load.
		step(1'b1, make_i(exec_pkg::class_load, exec_pkg::alu_add, 4'd6, 4'd1, 1'b0,
			16'h0130), 1'b0);
		step(1'b0, 32'h0, 1'b0);
		step(1'b0, 32'h0, 1'b1);
		drain();
		check_cr(3'd4);
		drain();
		step(1'b0, 32'h0, 1'b0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- sources.f
exec_pkg.sv
instr_decode.sv
reg_file.sv
alu.sv
ctrl_regs.sv
exec_stage.sv
exec_top.sv
tb_exec_top.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator, then decide from the log.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_exec_top -o sim_exec_top > build.log 2>&1 || { echo "build failed"; exit 1; }
./obj_dir/sim_exec_top > sim.log 2>&1 || true
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || \
	grep -q "Verification passed" sim.log && exit 0 || exit 1
